// File: bench/dma_ctrl_properties.sv
// bus and interrupt assertions
`timescale 1ns/100ps
`default_nettype none

`include "dma_ctrl_settings.svh"

module dma_ctrl_properties
   import dma_ctrl_pkg::*;
(
   input logic        wb_clk_i,
   input logic        wb_rst_i,
   input logic        wbm_cyc_o,
   input logic        wbm_ack_i,
   input logic        wbm_rty_i,
   input logic        wbm_err_i,
   input logic [31:0] wbm_adr_o,
   input logic        busy_o,
   input logic        irq_o,
   input logic        irq_clear_i,
   input logic        ch_release_o,
   input logic        ch_start_o,
   input count_t      ctl_i
);

   int         fail_cnt = 0;
   logic [2:0] acc_cnt;   // clean acks in current burst
   logic       accept;

   assign accept = wbm_ack_i & ~wbm_rty_i & ~wbm_err_i;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         acc_cnt <= '0;
      end else if (!wbm_cyc_o) begin
         acc_cnt <= '0;
      end else if (accept) begin
         acc_cnt <= acc_cnt + 1'b1;
      end
   end

   a_adr_step : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wbm_cyc_o && accept |=> wbm_adr_o == $past(wbm_adr_o) + 32'd8)
      else begin
         fail_cnt++;
         $error("address did not step after an accepted beat");
      end

   // retry, error or wait keeps the beat
   a_adr_hold : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wbm_cyc_o && !accept |=> $stable(wbm_adr_o))
      else begin
         fail_cnt++;
         $error("address moved without a clean ack");
      end

   a_four_beats : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $fell(wbm_cyc_o) |-> acc_cnt == 3'd4)
      else begin
         fail_cnt++;
         $error("burst ended without four accepted beats");
      end

   a_irq_rise : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(irq_o) |-> $past(ch_release_o && ctl_i[`DMA_CTL_IRQ]))
      else begin
         fail_cnt++;
         $error("interrupt set without a flagged release");
      end

   a_irq_clear : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      irq_clear_i && !ch_release_o |=> !irq_o)
      else begin
         fail_cnt++;
         $error("interrupt stayed set after clear");
      end

   a_start_drop : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      ch_release_o |=> !ch_start_o)
      else begin
         fail_cnt++;
         $error("channel start still high after release");
      end

   a_chain_end : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      ch_release_o && !ctl_i[`DMA_CTL_CHAIN] |=> ##1 (!busy_o && !wbm_cyc_o))
      else begin
         fail_cnt++;
         $error("controller not idle after the last descriptor");
      end

endmodule

`default_nettype wire

// File: bench/dma_ctrl_tb.sv
// DMA controller testbench
`timescale 1ns/100ps
`default_nettype none

`include "dma_ctrl_settings.svh"

module dma_ctrl_tb
   import dma_ctrl_pkg::*;
();

   localparam int JOBS       = 3;
   localparam int BEAT_MAX   = 16;   // worst case cycles per beat with retries
   localparam int RUN_MAX    = 16;
   localparam int TIMEOUT_NS = 8 * (8 + JOBS * (8 * BEAT_MAX + RUN_MAX + 16) + 64);

   logic        wb_clk_i, wb_rst_i, enable_i, start_i, irq_clear_i;
   addr_t       desc_adr_i;
   logic [31:0] wbm_adr_o;
   logic [7:0]  wbm_sel_o;
   data_t       wbm_dat_o, wbm_dat_i;
   logic        wbm_cyc_o, wbm_stb_o, wbm_we_o, wbm_ack_i, wbm_rty_i, wbm_err_i;
   logic        ch_start_o, ch_release_o, ch_done_i, ch_we_o;
   count_t      ch_ocnt_i;
   err_t        ch_err_i;
   beat_t       ch_adr_o;
   data_t       ch_dat_o;
   logic        busy_o, irq_o;
   addr_t       cur_desc_o;

   data_t   mem [0:255];          // 2 KB of 64-bit words
   addr_t   desc_list [0:JOBS-1];
   addr_t   wb_list [0:JOBS-1];
   count_t  ctl_list [0:JOBS-1];
   integer  seed, errors, job, beat_cnt, ch_cnt, wait_cnt;
   cycles_t run_cycles;          // start rise to done, counted here
   logic    rel_d, clr_d;

   dma_ctrl_top i_dut (.*);

   bind dma_ctrl_top dma_ctrl_properties i_props (.*, .ctl_i(ctl));

   function automatic count_t ocnt_for(input int j);
      ocnt_for = count_t'(16'h0100 + j);
   endfunction

   function automatic err_t err_for(input int j);
      err_for = err_t'(j + 1);
   endfunction

   task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
      assert (got === exp) else begin
         errors++;
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // three chained descriptors over a filled memory
   task automatic build_memory();
      for (int i = 0; i < 256; i++) begin
         mem[i] = {32'hc0de_0000 | i, 32'h5a00_0000 ^ (i * 32'h0101)};
      end
      desc_list = '{29'h20, 29'h40, 29'h60};   // 0x100, 0x200, 0x300
      wb_list   = '{29'h80, 29'ha0, 29'hc0};
      ctl_list  = '{16'h0011 | 16'(1 << `DMA_CTL_CHAIN) | 16'(1 << `DMA_CTL_WB),
                    16'h0022 | 16'(1 << `DMA_CTL_CHAIN) | 16'(1 << `DMA_CTL_IRQ),
                    16'h0033 | 16'(1 << `DMA_CTL_WB) | 16'(1 << `DMA_CTL_IRQ)};
      for (int j = 0; j < JOBS; j++) begin
         mem[desc_list[j][10:3]] = {wb_list[j], 3'b000,
                                    (j < JOBS - 1) ? desc_list[j + 1] : addr_t'(0), 3'b000};
         mem[desc_list[j][10:3] + 1][15:0] = ctl_list[j];
      end
   endtask

   initial begin
      wb_clk_i = 1'b0;
      forever #4 wb_clk_i = ~wb_clk_i;
   end

   // memory slave with random waits, retries and errors
   always @(posedge wb_clk_i) begin
      integer r;
      r = $random(seed) & 7;
      wbm_ack_i <= 1'b0;
      wbm_rty_i <= 1'b0;
      wbm_err_i <= 1'b0;
      if (wbm_cyc_o && wbm_stb_o && !wbm_ack_i && !wbm_rty_i && !wbm_err_i) begin
         if (r == 0) begin
            wbm_rty_i <= 1'b1;
         end else if (r == 1) begin
            wbm_err_i <= 1'b1;
         end else if (r >= 4) begin
            wbm_ack_i <= 1'b1;
            wbm_dat_i <= mem[wbm_adr_o[10:3]];
         end
      end
   end

   // channel finishes a random number of cycles after start
   always @(posedge wb_clk_i) begin
      if (!ch_start_o) begin
         ch_done_i <= 1'b0;
         wait_cnt  <= $random(seed) & 7;
         ch_ocnt_i <= ocnt_for(job);
         ch_err_i  <= err_for(job);
      end else if (wait_cnt == 0) begin
         ch_done_i <= 1'b1;   // level until start falls
      end else begin
         wait_cnt <= wait_cnt - 1;
      end
   end

   always @(posedge wb_clk_i) begin
      data_t exp_wb;
      if (!wb_rst_i) begin
         run_cycles <= (!ch_start_o) ? 32'd0 : run_cycles + !ch_done_i;
         expect_equal(wbm_stb_o, wbm_cyc_o, "bus strobe");
         expect_equal(wbm_sel_o, wbm_cyc_o ? 8'hff : 8'h00, "byte select");
         if (wbm_cyc_o && wbm_ack_i) begin
            expect_equal(wbm_adr_o[31:3],
                         addr_t'((wbm_we_o ? wb_list[job] : desc_list[job]) + beat_cnt),
                         "burst address");
            if (wbm_we_o) begin
               case (beat_cnt)
                  0:       exp_wb = data_t'(ocnt_for(job));
                  1:       exp_wb = data_t'(err_for(job));
                  2:       exp_wb = data_t'(run_cycles);
                  default: exp_wb = data_t'(ctl_list[job]);
               endcase
               expect_equal(wbm_dat_o, exp_wb, "write-back beat");
               mem[wbm_adr_o[10:3]] = wbm_dat_o;
            end
            beat_cnt <= (beat_cnt + 1) % 4;
         end
         if (ch_we_o) begin
            expect_equal(ch_adr_o, ch_cnt % 4, "channel slot index");
            expect_equal(ch_dat_o, mem[desc_list[job][10:3] + ch_cnt % 4],
                         "channel slot data");
            ch_cnt <= ch_cnt + 1;
         end
         rel_d       <= ch_release_o;
         clr_d       <= irq_clear_i;
         irq_clear_i <= 1'b0;
         if (rel_d) begin
            expect_equal(cur_desc_o, desc_list[job], "completed descriptor");
            expect_equal(irq_o, ctl_list[job][`DMA_CTL_IRQ], "interrupt after release");
            expect_equal(ch_cnt, 4 * (job + 1), "channel slot writes");
            irq_clear_i <= 1'b1;
            job         <= job + 1;
         end
         if (clr_d) begin
            expect_equal(irq_o, 1'b0, "interrupt after clear");
         end
      end
   end

   initial begin
      seed = 32'hdc72;
      {errors, job, beat_cnt, ch_cnt, wait_cnt} = '0;
      {rel_d, clr_d, run_cycles} = '0;
      {wb_rst_i, enable_i, start_i, irq_clear_i, desc_adr_i} = {1'b1, 32'd0};
      {wbm_dat_i, wbm_ack_i, wbm_rty_i, wbm_err_i} = '0;
      {ch_done_i, ch_ocnt_i, ch_err_i} = '0;
      build_memory();
      repeat (4) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;
      enable_i <= 1'b1;
      @(posedge wb_clk_i);
      start_i    <= 1'b1;
      desc_adr_i <= desc_list[0];
      @(posedge wb_clk_i);
      start_i <= 1'b0;
      wait (job == JOBS && !busy_o);
      repeat (4) @(posedge wb_clk_i);   // last clear and idle checks
      $display("checks done: %0d testbench errors, %0d assertion errors",
               errors, i_dut.i_props.fail_cnt);
      if (errors == 0 && i_dut.i_props.fail_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the descriptor chain did not finish within %0d ns", TIMEOUT_NS);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: dma_ctrl_top.f
+incdir+source
source/dma_ctrl_pkg.sv
source/dma_beat_if.sv
source/dma_beat_counter.sv
source/dma_desc_regs.sv
source/dma_status_gen.sv
source/dma_desc_fsm.sv
source/dma_ctrl_top.sv
bench/dma_ctrl_properties.sv
bench/dma_ctrl_tb.sv

// File: source/dma_beat_counter.sv
// burst beat counter
`timescale 1ns/100ps
`default_nettype none

`include "dma_ctrl_settings.svh"

module dma_beat_counter
   import dma_ctrl_pkg::*;
(
   input  logic         wb_clk_i,
   input  logic         wb_rst_i,
   input  logic         wbm_ack_i,
   input  logic         wbm_rty_i,
   input  logic         wbm_err_i,
   dma_beat_if.counter  bi
);

   // retry and error never count as a beat
   assign bi.accept = wbm_ack_i & ~wbm_rty_i & ~wbm_err_i;
   assign bi.last   = (bi.beat == beat_t'(`DMA_BURST_LEN - 1));

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         bi.beat <= '0;
      end else if (bi.load) begin
         bi.beat <= '0;               // new burst
      end else if (bi.accept) begin
         bi.beat <= bi.beat + 1'b1;   // wraps after last beat
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (bi.load) begin
         bi.adr <= bi.load_adr;
      end else if (bi.accept) begin
         bi.adr <= bi.adr + 1'b1;     // next 64-bit word
      end
   end

endmodule

`default_nettype wire

// File: source/dma_beat_if.sv
// burst progress interface
`timescale 1ns/100ps
`default_nettype none

interface dma_beat_if
   import dma_ctrl_pkg::*;
();

   logic    load;       // restart burst
   addr_t   load_adr;   // first address of burst
   logic    accept;     // clean ack this cycle
   beat_t   beat;       // current beat index
   logic    last;       // final beat of burst
   addr_t   adr;        // current beat address

   modport counter (input load, load_adr, output accept, beat, last, adr);
   modport fsm     (output load, load_adr, input accept, beat, last, adr);
   modport user    (input accept, beat, last, adr);

endinterface

`default_nettype wire

// File: source/dma_ctrl_pkg.sv
// DMA controller types
`default_nettype none

`include "dma_ctrl_settings.svh"

package dma_ctrl_pkg;

   typedef logic [31:3]             addr_t;    // 8-byte aligned address
   typedef logic [`DMA_DATA_W-1:0]  data_t;    // one bus beat
   typedef logic [1:0]              beat_t;    // beat index in a burst
   typedef logic [15:0]             count_t;   // job control word
   typedef logic [31:0]             cycles_t;  // job cycle timer
   typedef logic [2:0]              err_t;     // channel error code

   // job sequencing states
   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      DECIDE,
      RUN,
      WRITEBACK,
      RELEASE,
      NEXT
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/dma_ctrl_settings.svh
// DMA controller settings
`ifndef DMA_CTRL_SETTINGS_SVH
`define DMA_CTRL_SETTINGS_SVH

// bus and burst shape
`define DMA_DATA_W    64   // bus beat width
`define DMA_BURST_LEN 4    // beats per burst

// control word bits of a descriptor
`define DMA_CTL_WB    7    // write status record back
`define DMA_CTL_CHAIN 10   // fetch next descriptor
`define DMA_CTL_IRQ   11   // interrupt on completion

`endif

// File: source/dma_ctrl_top.sv
// DMA job controller top
`timescale 1ns/100ps
`default_nettype none

`include "dma_ctrl_settings.svh"

module dma_ctrl_top
   import dma_ctrl_pkg::*;
(
   input  logic                      wb_clk_i,
   input  logic                      wb_rst_i,
   input  logic                      enable_i,
   input  logic                      start_i,
   input  addr_t                     desc_adr_i,
   input  logic                      irq_clear_i,
   output logic [31:0]               wbm_adr_o,
   output logic [`DMA_DATA_W/8-1:0]  wbm_sel_o,
   output data_t                     wbm_dat_o,
   input  data_t                     wbm_dat_i,
   output logic                      wbm_cyc_o,
   output logic                      wbm_stb_o,
   output logic                      wbm_we_o,
   input  logic                      wbm_ack_i,
   input  logic                      wbm_rty_i,
   input  logic                      wbm_err_i,
   output logic                      ch_start_o,
   output logic                      ch_release_o,
   input  logic                      ch_done_i,
   input  count_t                    ch_ocnt_i,
   input  err_t                      ch_err_i,
   output logic                      ch_we_o,
   output beat_t                     ch_adr_o,
   output data_t                     ch_dat_o,
   output logic                      busy_o,
   output logic                      irq_o,
   output addr_t                     cur_desc_o
);

   ctrl_state_t state;
   addr_t       next_adr, wb_adr, fetch_adr;
   count_t      ctl;

   dma_beat_if bi ();

   assign wbm_adr_o = {bi.adr, 3'b000};
   assign wbm_sel_o = {(`DMA_DATA_W/8){wbm_cyc_o}};   // full beats only

   dma_beat_counter i_beat (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .wbm_ack_i (wbm_ack_i),
      .wbm_rty_i (wbm_rty_i),
      .wbm_err_i (wbm_err_i),
      .bi        (bi)
   );

   dma_desc_regs i_regs (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .state_i     (state),
      .wbm_dat_i   (wbm_dat_i),
      .bi          (bi),
      .next_adr_o  (next_adr),
      .wb_adr_o    (wb_adr),
      .fetch_adr_o (fetch_adr),
      .ctl_o       (ctl),
      .ch_we_o     (ch_we_o),
      .ch_adr_o    (ch_adr_o),
      .ch_dat_o    (ch_dat_o)
   );

   dma_status_gen i_status (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .ch_start_i (ch_start_o),
      .ch_done_i  (ch_done_i),
      .ch_ocnt_i  (ch_ocnt_i),
      .ch_err_i   (ch_err_i),
      .ctl_i      (ctl),
      .bi         (bi),
      .wbm_dat_o  (wbm_dat_o)
   );

   dma_desc_fsm i_fsm (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .enable_i     (enable_i),
      .start_i      (start_i),
      .desc_adr_i   (desc_adr_i),
      .next_adr_i   (next_adr),
      .wb_adr_i     (wb_adr),
      .ctl_i        (ctl),
      .ch_done_i    (ch_done_i),
      .irq_clear_i  (irq_clear_i),
      .fetch_adr_i  (fetch_adr),
      .bi           (bi),
      .state_o      (state),
      .wbm_cyc_o    (wbm_cyc_o),
      .wbm_stb_o    (wbm_stb_o),
      .wbm_we_o     (wbm_we_o),
      .ch_start_o   (ch_start_o),
      .ch_release_o (ch_release_o),
      .busy_o       (busy_o),
      .irq_o        (irq_o),
      .cur_desc_o   (cur_desc_o)
   );

endmodule

`default_nettype wire

// File: source/dma_desc_fsm.sv
// descriptor job sequencer
`timescale 1ns/100ps
`default_nettype none

`include "dma_ctrl_settings.svh"

module dma_desc_fsm
   import dma_ctrl_pkg::*;
(
   input  logic         wb_clk_i,
   input  logic         wb_rst_i,
   input  logic         enable_i,
   input  logic         start_i,
   input  addr_t        desc_adr_i,
   input  addr_t        next_adr_i,
   input  addr_t        wb_adr_i,
   input  count_t       ctl_i,
   input  logic         ch_done_i,
   input  logic         irq_clear_i,
   input  addr_t        fetch_adr_i,
   dma_beat_if.fsm      bi,
   output ctrl_state_t  state_o,
   output logic         wbm_cyc_o,
   output logic         wbm_stb_o,
   output logic         wbm_we_o,
   output logic         ch_start_o,
   output logic         ch_release_o,
   output logic         busy_o,
   output logic         irq_o,
   output addr_t        cur_desc_o
);

   ctrl_state_t state_q, state_d;
   logic        cyc_d, stb_d, we_d;
   logic        start_d;
   logic        irq_set;

   assign state_o      = state_q;
   assign busy_o       = (state_q != IDLE);
   assign ch_release_o = (state_q == RELEASE);   // one-cycle pulse
   assign irq_set      = (state_q == RELEASE) && ctl_i[`DMA_CTL_IRQ];

   always_comb begin
      state_d     = state_q;
      cyc_d       = wbm_cyc_o;
      stb_d       = wbm_stb_o;
      we_d        = wbm_we_o;
      start_d     = ch_start_o;
      bi.load     = 1'b0;
      bi.load_adr = desc_adr_i;

      case (state_q)
         IDLE: begin
            if (start_i && enable_i) begin
               bi.load = 1'b1;
               cyc_d   = 1'b1;
               stb_d   = 1'b1;
               we_d    = 1'b0;
               state_d = FETCH;
            end
         end
         FETCH: begin
            if (bi.accept && bi.last) begin
               cyc_d   = 1'b0;
               stb_d   = 1'b0;
               state_d = DECIDE;
            end
         end
         DECIDE: begin
            start_d = 1'b1;   // hand job to channel
            state_d = RUN;
         end
         RUN: begin
            bi.load_adr = wb_adr_i;
            if (ch_done_i) begin
               if (ctl_i[`DMA_CTL_WB]) begin
                  bi.load = 1'b1;
                  cyc_d   = 1'b1;
                  stb_d   = 1'b1;
                  we_d    = 1'b1;
                  state_d = WRITEBACK;
               end else begin
                  state_d = RELEASE;
               end
            end
         end
         WRITEBACK: begin
            if (bi.accept && bi.last) begin
               cyc_d   = 1'b0;
               stb_d   = 1'b0;
               we_d    = 1'b0;
               state_d = RELEASE;
            end
         end
         RELEASE: begin
            start_d = 1'b0;
            state_d = NEXT;
         end
         NEXT: begin
            bi.load_adr = next_adr_i;
            if (ctl_i[`DMA_CTL_CHAIN]) begin
               bi.load = 1'b1;   // follow the chain
               cyc_d   = 1'b1;
               stb_d   = 1'b1;
               we_d    = 1'b0;
               state_d = FETCH;
            end else begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q    <= IDLE;
         wbm_cyc_o  <= 1'b0;
         wbm_stb_o  <= 1'b0;
         wbm_we_o   <= 1'b0;
         ch_start_o <= 1'b0;
      end else begin
         state_q    <= state_d;
         wbm_cyc_o  <= cyc_d;
         wbm_stb_o  <= stb_d;
         wbm_we_o   <= we_d;
         ch_start_o <= start_d;
      end
   end

   // sticky interrupt where a new completion wins over clear
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         irq_o <= 1'b0;
      end else if (irq_set) begin
         irq_o <= 1'b1;
      end else if (irq_clear_i) begin
         irq_o <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         cur_desc_o <= '0;
      end else if (state_q == RELEASE) begin
         cur_desc_o <= fetch_adr_i;   // last completed descriptor
      end
   end

endmodule

`default_nettype wire

// File: source/dma_desc_regs.sv
// descriptor field capture
`timescale 1ns/100ps
`default_nettype none

module dma_desc_regs
   import dma_ctrl_pkg::*;
(
   input  logic         wb_clk_i,
   input  logic         wb_rst_i,
   input  ctrl_state_t  state_i,
   input  data_t        wbm_dat_i,
   dma_beat_if.user     bi,
   output addr_t        next_adr_o,
   output addr_t        wb_adr_o,
   output addr_t        fetch_adr_o,
   output count_t       ctl_o,
   output logic         ch_we_o,
   output beat_t        ch_adr_o,
   output data_t        ch_dat_o
);

   logic fetch_beat;

   assign fetch_beat = (state_i == FETCH) && bi.accept;

   // address words from beat 0
   always_ff @(posedge wb_clk_i) begin
      if (fetch_beat && bi.beat == 2'd0) begin
         next_adr_o  <= wbm_dat_i[31:3];    // chain pointer
         wb_adr_o    <= wbm_dat_i[63:35];   // status record address
         fetch_adr_o <= bi.adr;             // this descriptor
      end
   end

   // control word from beat 1 steers the fsm
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ctl_o <= '0;
      end else if (fetch_beat && bi.beat == 2'd1) begin
         ctl_o <= wbm_dat_i[15:0];
      end
   end

   // every fetched beat also lands in the channel slot memory
   assign ch_we_o  = fetch_beat;
   assign ch_adr_o = bi.beat;
   assign ch_dat_o = wbm_dat_i;

endmodule

`default_nettype wire

// File: source/dma_status_gen.sv
// job timer and status record
`timescale 1ns/100ps
`default_nettype none

module dma_status_gen
   import dma_ctrl_pkg::*;
(
   input  logic      wb_clk_i,
   input  logic      wb_rst_i,
   input  logic      ch_start_i,
   input  logic      ch_done_i,
   input  count_t    ch_ocnt_i,
   input  err_t      ch_err_i,
   input  count_t    ctl_i,
   dma_beat_if.user  bi,
   output data_t     wbm_dat_o
);

   cycles_t timer;
   logic    done_seen;   // freezes timer until channel released

   // timer sits at zero until start rises, then counts up to done
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         timer     <= '0;
         done_seen <= 1'b0;
      end else if (!ch_start_i) begin
         timer     <= '0;
         done_seen <= 1'b0;
      end else if (ch_done_i || done_seen) begin
         done_seen <= 1'b1;   // hold value
      end else begin
         timer <= timer + 1'b1;
      end
   end

   always_comb begin
      case (bi.beat)
         2'd0:    wbm_dat_o = data_t'(ch_ocnt_i);
         2'd1:    wbm_dat_o = data_t'(ch_err_i);
         2'd2:    wbm_dat_o = data_t'(timer);
         default: wbm_dat_o = data_t'(ctl_i);
      endcase
   end

endmodule

`default_nettype wire
